//--- tb.f
rtl/csr_addr_pkg.sv
rtl/csr_excp_pkg.sv
rtl/csr_excp_ctrl.sv
rtl/csr_timer.sv
rtl/csr_regfile.sv
rtl/csr_top.sv
verif/csr_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the CSR testbench with Verilator.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert --top-module csr_tb -Mdir obj_dir -f tb.f; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vcsr_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
  exit 1
fi

exit 0

//--- verif/csr_tb.sv
`default_nettype none

module csr_tb
  import csr_addr_pkg::*;
  import csr_excp_pkg::*;
();

  localparam csr_data_t TID_INIT = 32'h0000_5a17;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        stall_i;
  logic        csr_we_i;
  csr_addr_t   csr_w_addr_i;
  csr_data_t   csr_w_mask_i;
  csr_data_t   csr_w_data_i;
  csr_addr_t   csr_r_addr_i;
  rdcnt_t      rdcnt_i;
  logic [7:0]  int_i;
  excp_vec_t   excp_i;
  logic        ertn_i;
  csr_data_t   pc_i;
  csr_data_t   vaddr_i;
  csr_data_t   csr_r_data_o;
  logic        int_o;
  csr_data_t   eentry_o;
  csr_data_t   era_o;

  logic [31:0] seed = 32'h83cb51c2;
  int unsigned cyc = 0;
  int unsigned last_wr_edge;
  int unsigned last_rd_edge;
  int          n_prop_errors = 0;
  int          n_checks;
  int          n_errors;
  int          n_tests;
  int          n_passed;
  int          test_err_base;
  // expected software view, keyed by csr address
  csr_data_t   model_q [csr_addr_t];
  logic [14:0] estat_code_m;

  csr_top #(
    .TID_INIT (TID_INIT)
  ) i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .stall_i      (stall_i),
    .csr_we_i     (csr_we_i),
    .csr_w_addr_i (csr_w_addr_i),
    .csr_w_mask_i (csr_w_mask_i),
    .csr_w_data_i (csr_w_data_i),
    .csr_r_addr_i (csr_r_addr_i),
    .rdcnt_i      (rdcnt_i),
    .int_i        (int_i),
    .excp_i       (excp_i),
    .ertn_i       (ertn_i),
    .pc_i         (pc_i),
    .vaddr_i      (vaddr_i),
    .csr_r_data_o (csr_r_data_o),
    .int_o        (int_o),
    .eentry_o     (eentry_o),
    .era_o        (era_o)
  );

  always #2 clk = ~clk;

  // counts rising edges for the negedge samplers
  always @(posedge clk) cyc <= cyc + 1;

  // read register holds across a stalled edge
  assert property (@(posedge clk) disable iff (!rst_n) stall_i |=> $stable(csr_r_data_o))
    else begin
      n_prop_errors++;
      $display("Error at %0t: csr_r_data_o changed after a stalled edge", $time);
    end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic csr_data_t field_mask(input csr_addr_t addr);
    case (addr)
      CSR_CRMD, CSR_PRMD: return 32'h0000_0007;
      CSR_ECTL:           return 32'h0000_1bff;
      CSR_EENTRY:         return 32'hffff_ffc0;
      CSR_ERA, CSR_BADV, CSR_TID,
      CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3: return 32'hffff_ffff;
      default:            return 32'h0;
    endcase
  endfunction

  // lowest set index wins
  function automatic int top_cause(input excp_vec_t v);
    int i;
    top_cause = -1;
    for (i = EXC_W - 1; i >= 0; i--) begin
      if (v[i]) top_cause = i;
    end
  endfunction

  function automatic ecode_t cause_ecode(input int idx);
    case (idx)
      EXC_ADEF, EXC_ADEM: return ECODE_ADE;
      EXC_ALE:            return ECODE_ALE;
      EXC_SYS:            return ECODE_SYS;
      EXC_BRK:            return ECODE_BRK;
      EXC_INE:            return ECODE_INE;
      EXC_IPE:            return ECODE_IPE;
      default:            return ECODE_INT;
    endcase
  endfunction

  task automatic check_value(input string what, input csr_data_t got, input csr_data_t exp);
    n_checks++;
    assert (got === exp) else begin
      n_errors++;
      $display("Error at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic write_csr(input csr_addr_t addr, input csr_data_t data,
                           input csr_data_t mask);
    csr_data_t fm;
    fm = field_mask(addr);
    @(posedge clk);
    csr_we_i     <= 1'b1;
    csr_w_addr_i <= addr;
    csr_w_data_i <= data;
    csr_w_mask_i <= mask;
    @(posedge clk);
    csr_we_i <= 1'b0;
    @(negedge clk);
    last_wr_edge = cyc;
    if (fm != 32'h0) begin
      model_q[addr] = ((model_q[addr] & ~mask) | (data & mask)) & fm;
    end
  endtask

  // result reflects state after edge last_rd_edge - 1
  task automatic read_csr(input csr_addr_t addr, input rdcnt_t rc, output csr_data_t data);
    @(posedge clk);
    csr_r_addr_i <= addr;
    rdcnt_i      <= rc;
    @(posedge clk);
    @(negedge clk);
    data         = csr_r_data_o;
    last_rd_edge = cyc;
  endtask

  task automatic check_read(input csr_addr_t addr);
    csr_data_t got;
    read_csr(addr, RDCNT_NONE, got);
    check_value($sformatf("read of csr %h", addr), got, model_q[addr]);
  endtask

  task automatic check_estat_code(input string what);
    csr_data_t got;
    read_csr(CSR_ESTAT, RDCNT_NONE, got);
    check_value(what, {17'b0, got[30:16]}, {17'b0, estat_code_m});
  endtask

  task automatic raise_excp(input excp_vec_t v, input csr_data_t pc, input csr_data_t va);
    @(posedge clk);
    excp_i  <= v;
    pc_i    <= pc;
    vaddr_i <= va;
    @(posedge clk);
    excp_i <= '0;
    @(negedge clk);
  endtask

  task automatic pulse_ertn();
    @(posedge clk);
    ertn_i <= 1'b1;
    @(posedge clk);
    ertn_i <= 1'b0;
    @(negedge clk);
  endtask

  task automatic wait_timer_irq();
    csr_data_t got;
    int        polls;
    got = '0;
    for (polls = 0; polls < 64 && !got[ESTAT_TI_BIT]; polls++) begin
      read_csr(CSR_ESTAT, RDCNT_NONE, got);
    end
    assert (got[ESTAT_TI_BIT]) else begin
      n_errors++;
      $display("timeout: timer interrupt never showed in ESTAT after %0d polls", polls);
    end
  endtask

  task automatic begin_test();
    test_err_base = n_errors + n_prop_errors;
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = n_errors + n_prop_errors - test_err_base;
    n_tests++;
    if (errs == 0) begin
      n_passed++;
      $display("test %s: ok", name);
    end else begin
      $display("test %s: FAILED with %0d errors", name, errs);
    end
  endtask

  task automatic test_counter();
    csr_data_t   a;
    csr_data_t   b;
    int unsigned ea;
    read_csr(CSR_CRMD, RDCNT_ID, a);
    check_value("rdcnt id before tid write", a, TID_INIT);
    read_csr(CSR_CRMD, RDCNT_VHIGH, a);
    check_value("rdcnt vhigh early", a, 32'h0);
    read_csr(CSR_CRMD, RDCNT_VLOW, a);
    ea = last_rd_edge;
    read_csr(CSR_CRMD, RDCNT_VLOW, b);
    check_value("vlow delta back to back", b - a, last_rd_edge - ea);
    a  = b;
    ea = last_rd_edge;
    repeat (7) @(posedge clk);
    read_csr(CSR_CRMD, RDCNT_VLOW, b);
    check_value("vlow delta with gap", b - a, last_rd_edge - ea);
  endtask

  task automatic test_masked_write();
    csr_addr_t targets [7];
    csr_addr_t addr;
    csr_data_t got;
    int        i;
    int        k;
    targets = '{CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_TID, CSR_EENTRY, CSR_ECTL};
    // save and eentry come out of reset unknown
    for (i = 0; i < 4; i++) begin
      write_csr(targets[i], next_rand(), 32'hffff_ffff);
    end
    write_csr(CSR_EENTRY, next_rand(), 32'hffff_ffff);
    for (i = 0; i < 28; i++) begin
      k    = int'(next_rand() % 32'd7);
      addr = targets[k];
      write_csr(addr, next_rand(), next_rand());
      read_csr(addr, RDCNT_NONE, got);
      check_value($sformatf("masked write to csr %h", addr), got, model_q[addr]);
    end
    check_value("eentry_o", eentry_o, model_q[CSR_EENTRY]);
    read_csr(14'h3, RDCNT_NONE, got);
    check_value("unimplemented csr 003", got, 32'h0);
    read_csr(14'h43, RDCNT_NONE, got);
    check_value("unimplemented csr 043", got, 32'h0);
    read_csr(14'h3fff, RDCNT_NONE, got);
    check_value("unimplemented csr 3fff", got, 32'h0);
  endtask

  task automatic test_exception();
    excp_vec_t   vecs [8];
    csr_data_t   pc;
    csr_data_t   va;
    logic [31:0] r;
    logic [2:0]  old;
    int          k;
    int          w;
    vecs = '{8'hfe, 8'hfc, 8'h88, 8'h70, 8'ha0, 8'hc0, 8'h80, 8'h03};
    write_csr(CSR_BADV, next_rand(), 32'hffff_ffff);
    for (k = 0; k < 8; k++) begin
      r   = next_rand();
      old = (k == 0) ? 3'b111 : r[2:0];
      pc  = next_rand();
      va  = next_rand();
      write_csr(CSR_CRMD, {29'b0, old}, 32'hffff_ffff);
      raise_excp(vecs[k], pc, va);
      w = top_cause(vecs[k]);
      model_q[CSR_PRMD] = {29'b0, old};
      model_q[CSR_CRMD] = 32'h0;
      model_q[CSR_ERA]  = pc;
      if (w == EXC_ADEF) begin
        model_q[CSR_BADV] = pc;
      end else if (w == EXC_ADEM || w == EXC_ALE) begin
        model_q[CSR_BADV] = va;
      end
      estat_code_m = {(w == EXC_ADEM) ? 9'd1 : 9'd0, cause_ecode(w)};
      check_read(CSR_CRMD);
      check_read(CSR_PRMD);
      check_read(CSR_ERA);
      check_read(CSR_BADV);
      check_estat_code($sformatf("estat codes for causes %h", vecs[k]));
      check_value("era_o", era_o, pc);
      pulse_ertn();
      model_q[CSR_CRMD] = model_q[CSR_PRMD];
      check_read(CSR_CRMD);
    end
  endtask

  task automatic test_stall();
    csr_data_t held;
    int        i;
    write_csr(CSR_SAVE1, next_rand(), 32'hffff_ffff);
    // crmd must differ from prmd so a leaked ertn shows up
    write_csr(CSR_CRMD, ~model_q[CSR_PRMD], 32'h0000_0007);
    read_csr(CSR_SAVE0, RDCNT_NONE, held);
    check_value("save0 before stall", held, model_q[CSR_SAVE0]);
    @(posedge clk);
    stall_i      <= 1'b1;
    csr_we_i     <= 1'b1;
    csr_w_addr_i <= CSR_SAVE0;
    csr_w_data_i <= ~held;
    csr_w_mask_i <= 32'hffff_ffff;
    excp_i       <= 8'h30;
    pc_i         <= next_rand();
    vaddr_i      <= next_rand();
    ertn_i       <= 1'b1;
    csr_r_addr_i <= CSR_SAVE1;
    rdcnt_i      <= RDCNT_VLOW;
    for (i = 0; i < 6; i++) begin
      @(negedge clk);
      check_value("read data under stall", csr_r_data_o, held);
      @(posedge clk);
    end
    stall_i  <= 1'b0;
    csr_we_i <= 1'b0;
    excp_i   <= '0;
    ertn_i   <= 1'b0;
    rdcnt_i  <= RDCNT_NONE;
    @(negedge clk);
    check_value("read data at stall release", csr_r_data_o, held);
    check_read(CSR_SAVE0);
    check_read(CSR_SAVE1);
    check_read(CSR_CRMD);
    check_read(CSR_PRMD);
    check_read(CSR_ERA);
    check_read(CSR_BADV);
    check_read(CSR_TID);
    check_estat_code("estat codes after stall");
    check_value("era_o after stall", era_o, model_q[CSR_ERA]);
  endtask

  task automatic test_timer();
    csr_data_t   got;
    int unsigned el;
    int          i;
    // one-shot with initval 6
    write_csr(CSR_TCFG, 32'h0000_0019, 32'hffff_ffff);
    for (i = 0; i < 3; i++) begin
      read_csr(CSR_TVAL, RDCNT_NONE, got);
      el = last_rd_edge - 1 - last_wr_edge;
      check_value("one-shot tval countdown", got, 32'd24 - el);
    end
    wait_timer_irq();
    read_csr(CSR_TVAL, RDCNT_NONE, got);
    check_value("one-shot tval after expiry", got, 32'hffff_ffff);
    read_csr(CSR_TCFG, RDCNT_NONE, got);
    check_value("one-shot tcfg after expiry", got, 32'h0000_0018);
    write_csr(CSR_TICLR, 32'h1, 32'hffff_ffff);
    read_csr(CSR_ESTAT, RDCNT_NONE, got);
    check_value("ti after one-shot clear", {31'b0, got[ESTAT_TI_BIT]}, 32'h0);
    // periodic with initval 3 gives a 13 cycle period
    write_csr(CSR_TCFG, 32'h0000_000f, 32'hffff_ffff);
    for (i = 0; i < 10; i++) begin
      read_csr(CSR_TVAL, RDCNT_NONE, got);
      el = last_rd_edge - 1 - last_wr_edge;
      check_value("periodic tval", got, 32'd12 - (el % 32'd13));
    end
    wait_timer_irq();
    write_csr(CSR_TCFG, 32'h0, 32'hffff_ffff);
    write_csr(CSR_TICLR, 32'h1, 32'h1);
    read_csr(CSR_ESTAT, RDCNT_NONE, got);
    check_value("ti after periodic clear", {31'b0, got[ESTAT_TI_BIT]}, 32'h0);
  endtask

  task automatic test_interrupt();
    logic [31:0] r;
    logic [12:0] lie;
    logic [12:0] is_m;
    logic        ie;
    logic        exp_int;
    csr_data_t   got;
    int          i;
    for (i = 0; i < 16; i++) begin
      r   = next_rand();
      lie = r[12:0] & 13'h1bff;
      ie  = r[13];
      write_csr(CSR_ECTL, {19'b0, r[12:0]}, 32'hffff_ffff);
      write_csr(CSR_CRMD, {29'b0, ie, 2'b00}, 32'hffff_ffff);
      write_csr(CSR_ESTAT, {30'b0, r[15:14]}, 32'h3);
      @(posedge clk);
      int_i <= r[23:16];
      @(posedge clk);
      @(negedge clk);
      // ti is clear and bits 10, 12 have no source
      is_m    = {3'b000, r[23:16], r[15:14]};
      exp_int = ie & (|(is_m & lie));
      check_value("int_o", {31'b0, int_o}, {31'b0, exp_int});
      read_csr(CSR_ESTAT, RDCNT_NONE, got);
      check_value("estat is field", {19'b0, got[12:0]}, {19'b0, is_m});
    end
    @(posedge clk);
    int_i <= '0;
    write_csr(CSR_ESTAT, 32'h0, 32'h3);
  endtask

  initial begin
    rst_n        = 1'b0;
    stall_i      = 1'b0;
    csr_we_i     = 1'b0;
    csr_w_addr_i = '0;
    csr_w_mask_i = '0;
    csr_w_data_i = '0;
    csr_r_addr_i = '0;
    rdcnt_i      = RDCNT_NONE;
    int_i        = '0;
    excp_i       = '0;
    ertn_i       = 1'b0;
    pc_i         = '0;
    vaddr_i      = '0;
    n_checks     = 0;
    n_errors     = 0;
    n_tests      = 0;
    n_passed     = 0;
    estat_code_m = '0;
    model_q[CSR_CRMD]   = 32'h0;
    model_q[CSR_PRMD]   = 32'h0;
    model_q[CSR_ECTL]   = 32'h0;
    model_q[CSR_TID]    = TID_INIT;
    model_q[CSR_ERA]    = 32'h0;
    model_q[CSR_BADV]   = 32'h0;
    model_q[CSR_EENTRY] = 32'h0;
    model_q[CSR_SAVE0]  = 32'h0;
    model_q[CSR_SAVE1]  = 32'h0;
    model_q[CSR_SAVE2]  = 32'h0;
    model_q[CSR_SAVE3]  = 32'h0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    begin_test();
    test_counter();
    end_test("stable counter reads");
    begin_test();
    test_masked_write();
    end_test("masked write and read-back");
    begin_test();
    test_exception();
    end_test("exception entry and ertn");
    begin_test();
    test_stall();
    end_test("stall");
    begin_test();
    test_timer();
    end_test("timer one-shot and periodic");
    begin_test();
    test_interrupt();
    end_test("interrupt summary");

    $display("summary: %0d tests, %0d passed, %0d checks, %0d errors",
             n_tests, n_passed, n_checks, n_errors + n_prop_errors);
    if (n_errors + n_prop_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- rtl/csr_top.sv
`default_nettype none

module csr_top
  import csr_addr_pkg::*;
  import csr_excp_pkg::*;
#(
  parameter csr_data_t TID_INIT = '0
) (
  input  wire logic       clk,
  input  wire logic       rst_n,
  input  wire logic       stall_i,
  input  wire logic       csr_we_i,
  input  wire csr_addr_t  csr_w_addr_i,
  input  wire csr_data_t  csr_w_mask_i,
  input  wire csr_data_t  csr_w_data_i,
  input  wire csr_addr_t  csr_r_addr_i,
  input  wire rdcnt_t     rdcnt_i,
  input  wire logic [7:0] int_i,
  input  wire excp_vec_t  excp_i,
  input  wire logic       ertn_i,
  input  wire csr_data_t  pc_i,
  input  wire csr_data_t  vaddr_i,
  output csr_data_t       csr_r_data_o,
  output logic            int_o,
  output csr_data_t       eentry_o,
  output csr_data_t       era_o
);

  logic        excp_valid;
  logic        ertn_valid;
  ecode_t      ecode;
  esubcode_t   esubcode;
  logic        badv_we;
  csr_data_t   badv;
  csr_data_t   era_val;
  logic        ti;
  csr_data_t   tcfg;
  csr_data_t   tval;
  stable_cnt_t stable_cnt;

  csr_excp_ctrl u_excp_ctrl (
    .stall_i      (stall_i),
    .excp_i       (excp_i),
    .ertn_i       (ertn_i),
    .pc_i         (pc_i),
    .vaddr_i      (vaddr_i),
    .excp_valid_o (excp_valid),
    .ertn_valid_o (ertn_valid),
    .ecode_o      (ecode),
    .esubcode_o   (esubcode),
    .badv_we_o    (badv_we),
    .badv_o       (badv),
    .era_val_o    (era_val)
  );

  csr_timer u_timer (
    .clk          (clk),
    .rst_n        (rst_n),
    .stall_i      (stall_i),
    .csr_we_i     (csr_we_i),
    .csr_w_addr_i (csr_w_addr_i),
    .csr_w_mask_i (csr_w_mask_i),
    .csr_w_data_i (csr_w_data_i),
    .ti_o         (ti),
    .tcfg_o       (tcfg),
    .tval_o       (tval),
    .stable_cnt_o (stable_cnt)
  );

  csr_regfile #(
    .TID_INIT (TID_INIT)
  ) u_regfile (
    .clk          (clk),
    .rst_n        (rst_n),
    .stall_i      (stall_i),
    .csr_we_i     (csr_we_i),
    .csr_w_addr_i (csr_w_addr_i),
    .csr_w_mask_i (csr_w_mask_i),
    .csr_w_data_i (csr_w_data_i),
    .csr_r_addr_i (csr_r_addr_i),
    .rdcnt_i      (rdcnt_i),
    .int_i        (int_i),
    .excp_valid_i (excp_valid),
    .ertn_valid_i (ertn_valid),
    .ecode_i      (ecode),
    .esubcode_i   (esubcode),
    .badv_we_i    (badv_we),
    .badv_i       (badv),
    .era_val_i    (era_val),
    .ti_i         (ti),
    .tcfg_i       (tcfg),
    .tval_i       (tval),
    .stable_cnt_i (stable_cnt),
    .csr_r_data_o (csr_r_data_o),
    .int_o        (int_o),
    .eentry_o     (eentry_o),
    .era_o        (era_o)
  );

endmodule

`default_nettype wire

//--- rtl/csr_regfile.sv
`default_nettype none

module csr_regfile
  import csr_addr_pkg::*;
  import csr_excp_pkg::*;
#(
  parameter csr_data_t TID_INIT = '0
) (
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire logic        stall_i,
  input  wire logic        csr_we_i,
  input  wire csr_addr_t   csr_w_addr_i,
  input  wire csr_data_t   csr_w_mask_i,
  input  wire csr_data_t   csr_w_data_i,
  input  wire csr_addr_t   csr_r_addr_i,
  input  wire rdcnt_t      rdcnt_i,
  input  wire logic [7:0]  int_i,
  input  wire logic        excp_valid_i,
  input  wire logic        ertn_valid_i,
  input  wire ecode_t      ecode_i,
  input  wire esubcode_t   esubcode_i,
  input  wire logic        badv_we_i,
  input  wire csr_data_t   badv_i,
  input  wire csr_data_t   era_val_i,
  input  wire logic        ti_i,
  input  wire csr_data_t   tcfg_i,
  input  wire csr_data_t   tval_i,
  input  wire stable_cnt_t stable_cnt_i,
  output csr_data_t        csr_r_data_o,
  output logic             int_o,
  output csr_data_t        eentry_o,
  output csr_data_t        era_o
);

  logic [1:0]  crmd_plv_q;
  logic        crmd_ie_q;
  logic [1:0]  prmd_pplv_q;
  logic        prmd_pie_q;
  logic [12:0] ectl_lie_q;
  logic [1:0]  estat_is_sw_q;
  ecode_t      estat_ecode_q;
  esubcode_t   estat_esub_q;
  logic [7:0]  int_q;
  csr_data_t   era_q;
  csr_data_t   badv_q;
  logic [25:0] eentry_va_q;
  csr_data_t   save_q [4];
  csr_data_t   tid_q;

  logic [12:0] estat_is;
  csr_data_t   crmd_v;
  csr_data_t   prmd_v;
  csr_data_t   ectl_v;
  csr_data_t   estat_v;
  csr_data_t   eentry_v;
  csr_data_t   w_cur;
  csr_data_t   w_data;
  logic        wen;

  // software view of each register
  assign estat_is = {1'b0, ti_i, 1'b0, int_q, estat_is_sw_q};

  always_comb begin
    crmd_v   = '0;
    prmd_v   = '0;
    ectl_v   = '0;
    estat_v  = '0;
    eentry_v = '0;
    crmd_v[CRMD_PLV_MSB:CRMD_PLV_LSB]   = crmd_plv_q;
    crmd_v[CRMD_IE]                     = crmd_ie_q;
    prmd_v[PRMD_PPLV_MSB:PRMD_PPLV_LSB] = prmd_pplv_q;
    prmd_v[PRMD_PIE]                    = prmd_pie_q;
    ectl_v[ECTL_LIE_MSB:ECTL_LIE_LSB]   = ectl_lie_q;
    estat_v[ESTAT_IS_MSB:ESTAT_IS_LSB]  = estat_is;
    estat_v[ESTAT_ECODE_MSB:ESTAT_ECODE_LSB]       = estat_ecode_q;
    estat_v[ESTAT_ESUBCODE_MSB:ESTAT_ESUBCODE_LSB] = estat_esub_q;
    eentry_v[EENTRY_VA_MSB:EENTRY_VA_LSB]          = eentry_va_q;
  end

  function automatic csr_data_t csr_view(input csr_addr_t addr);
    csr_data_t v;
    case (addr)
      CSR_CRMD:   v = crmd_v;
      CSR_PRMD:   v = prmd_v;
      CSR_ECTL:   v = ectl_v;
      CSR_ESTAT:  v = estat_v;
      CSR_ERA:    v = era_q;
      CSR_BADV:   v = badv_q;
      CSR_EENTRY: v = eentry_v;
      CSR_SAVE0:  v = save_q[0];
      CSR_SAVE1:  v = save_q[1];
      CSR_SAVE2:  v = save_q[2];
      CSR_SAVE3:  v = save_q[3];
      CSR_TID:    v = tid_q;
      CSR_TCFG:   v = tcfg_i;
      CSR_TVAL:   v = tval_i;
      default:    v = '0;
    endcase
    return v;
  endfunction

  // masked merge against the current value
  assign wen    = csr_we_i && !stall_i;

  always_comb begin
    w_cur = csr_view(csr_w_addr_i);
  end

  assign w_data = (w_cur & ~csr_w_mask_i) | (csr_w_data_i & csr_w_mask_i);

  // later assignments win so a write beats ertn and ertn beats an exception
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      crmd_plv_q    <= '0;
      crmd_ie_q     <= 1'b0;
      prmd_pplv_q   <= '0;
      prmd_pie_q    <= 1'b0;
      ectl_lie_q    <= '0;
      estat_is_sw_q <= '0;
      estat_ecode_q <= '0;
      estat_esub_q  <= '0;
      tid_q         <= TID_INIT;
    end else begin
      if (excp_valid_i) begin
        prmd_pplv_q   <= crmd_plv_q;
        prmd_pie_q    <= crmd_ie_q;
        crmd_plv_q    <= '0;
        crmd_ie_q     <= 1'b0;
        estat_ecode_q <= ecode_i;
        estat_esub_q  <= esubcode_i;
      end
      if (ertn_valid_i) begin
        crmd_plv_q <= prmd_pplv_q;
        crmd_ie_q  <= prmd_pie_q;
      end
      if (wen) begin
        case (csr_w_addr_i)
          CSR_CRMD: begin
            crmd_plv_q <= w_data[CRMD_PLV_MSB:CRMD_PLV_LSB];
            crmd_ie_q  <= w_data[CRMD_IE];
          end
          CSR_PRMD: begin
            prmd_pplv_q <= w_data[PRMD_PPLV_MSB:PRMD_PPLV_LSB];
            prmd_pie_q  <= w_data[PRMD_PIE];
          end
          CSR_ECTL:  ectl_lie_q    <= w_data[ECTL_LIE_MSB:ECTL_LIE_LSB] & ECTL_LIE_MASK;
          CSR_ESTAT: estat_is_sw_q <= w_data[1:0];
          CSR_TID:   tid_q         <= w_data;
          default: ;
        endcase
      end
    end
  end

  // hw lines land one cycle late
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      int_q <= '0;
    end else begin
      int_q <= int_i;
    end
  end

  always_ff @(posedge clk) begin
    if (excp_valid_i) begin
      era_q <= era_val_i;
    end
    if (excp_valid_i && badv_we_i) begin
      badv_q <= badv_i;
    end
    if (wen) begin
      case (csr_w_addr_i)
        CSR_ERA:    era_q       <= w_data;
        CSR_BADV:   badv_q      <= w_data;
        CSR_EENTRY: eentry_va_q <= w_data[EENTRY_VA_MSB:EENTRY_VA_LSB];
        CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3: begin
          save_q[csr_w_addr_i[1:0]] <= w_data;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i) begin
      case (rdcnt_i)
        RDCNT_ID:    csr_r_data_o <= tid_q;
        RDCNT_VLOW:  csr_r_data_o <= stable_cnt_i[31:0];
        RDCNT_VHIGH: csr_r_data_o <= stable_cnt_i[63:32];
        RDCNT_NONE:  csr_r_data_o <= csr_view(csr_r_addr_i);
      endcase
    end
  end

  assign int_o    = crmd_ie_q && |(estat_is & ectl_lie_q);
  assign eentry_o = eentry_v;
  assign era_o    = era_q;

endmodule

`default_nettype wire

//--- rtl/csr_timer.sv
`default_nettype none

module csr_timer
  import csr_addr_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire logic      stall_i,
  input  wire logic      csr_we_i,
  input  wire csr_addr_t csr_w_addr_i,
  input  wire csr_data_t csr_w_mask_i,
  input  wire csr_data_t csr_w_data_i,
  output logic           ti_o,
  output csr_data_t      tcfg_o,
  output csr_data_t      tval_o,
  output stable_cnt_t    stable_cnt_o
);

  csr_data_t   tcfg_q;
  csr_data_t   tval_q;
  logic        ti_q;
  stable_cnt_t stable_q;

  logic        wen;
  logic        tcfg_we;
  logic        ticlr_we;
  csr_data_t   tcfg_merged;
  csr_data_t   ticlr_merged;
  csr_data_t   tval_reload;
  logic        timer_on;
  logic        tval_zero;

  assign wen = csr_we_i && !stall_i;

  assign tcfg_merged  = (tcfg_q & ~csr_w_mask_i) | (csr_w_data_i & csr_w_mask_i);
  // ticlr always reads zero, so only the new bits count
  assign ticlr_merged = csr_w_data_i & csr_w_mask_i;

  assign tcfg_we  = wen && (csr_w_addr_i == CSR_TCFG);
  assign ticlr_we = wen && (csr_w_addr_i == CSR_TICLR) && ticlr_merged[TICLR_CLR];

  assign tval_reload = {tcfg_q[TCFG_INITVAL_MSB:TCFG_INITVAL_LSB], 2'b00};
  assign timer_on    = tcfg_q[TCFG_EN];
  assign tval_zero   = (tval_q == '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tcfg_q <= '0;
      tval_q <= '0;
    end else if (tcfg_we) begin
      tcfg_q <= tcfg_merged;
      tval_q <= {tcfg_merged[TCFG_INITVAL_MSB:TCFG_INITVAL_LSB], 2'b00};
    end else if (timer_on) begin
      if (!tval_zero) begin
        tval_q <= tval_q - 32'd1;
      end else if (tcfg_q[TCFG_PERIODIC]) begin
        tval_q <= tval_reload;
      end else begin
        // one-shot expiry parks at all ones
        tval_q          <= '1;
        tcfg_q[TCFG_EN] <= 1'b0;
      end
    end
  end

  // clear beats a same-cycle expiry
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ti_q <= 1'b0;
    end else if (ticlr_we) begin
      ti_q <= 1'b0;
    end else if (timer_on && tval_zero) begin
      ti_q <= 1'b1;
    end
  end

  // free running, stall does not hold it
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stable_q <= '0;
    end else begin
      stable_q <= stable_q + 64'd1;
    end
  end

  assign ti_o         = ti_q;
  assign tcfg_o       = tcfg_q;
  assign tval_o       = tval_q;
  assign stable_cnt_o = stable_q;

endmodule

`default_nettype wire

//--- rtl/csr_excp_ctrl.sv
`default_nettype none

module csr_excp_ctrl
  import csr_addr_pkg::*;
  import csr_excp_pkg::*;
(
  input  wire logic      stall_i,
  input  wire excp_vec_t excp_i,
  input  wire logic      ertn_i,
  input  wire csr_data_t pc_i,
  input  wire csr_data_t vaddr_i,
  output logic           excp_valid_o,
  output logic           ertn_valid_o,
  output ecode_t         ecode_o,
  output esubcode_t      esubcode_o,
  output logic           badv_we_o,
  output csr_data_t      badv_o,
  output csr_data_t      era_val_o
);

  excp_vec_t excp_live;
  logic      adef_win;
  logic      va_win;

  // nothing commits while stalled
  assign excp_live    = stall_i ? '0 : excp_i;
  assign excp_valid_o = |excp_live;
  assign ertn_valid_o = ertn_i && !stall_i;

  always_comb begin
    ecode_o    = ECODE_INT;
    esubcode_o = ESUB_NONE;
    adef_win   = 1'b0;
    va_win     = 1'b0;
    if (excp_live[EXC_INT]) begin
      ecode_o = ECODE_INT;
    end else if (excp_live[EXC_ADEF]) begin
      ecode_o  = ECODE_ADE;
      adef_win = 1'b1;
      va_win   = 1'b1;
    end else if (excp_live[EXC_ADEM]) begin
      ecode_o    = ECODE_ADE;
      esubcode_o = ESUB_ADEM;
      va_win     = 1'b1;
    end else if (excp_live[EXC_ALE]) begin
      ecode_o = ECODE_ALE;
      va_win  = 1'b1;
    end else if (excp_live[EXC_SYS]) begin
      ecode_o = ECODE_SYS;
    end else if (excp_live[EXC_BRK]) begin
      ecode_o = ECODE_BRK;
    end else if (excp_live[EXC_INE]) begin
      ecode_o = ECODE_INE;
    end else if (excp_live[EXC_IPE]) begin
      ecode_o = ECODE_IPE;
    end
  end

  // fetch faults report the pc, data faults the access address
  assign badv_we_o = va_win;
  assign badv_o    = adef_win ? pc_i : vaddr_i;
  assign era_val_o = pc_i;

endmodule

`default_nettype wire

//--- rtl/csr_excp_pkg.sv
`default_nettype none

package csr_excp_pkg;

  localparam int EXC_W = 8;

  // index order doubles as priority, lowest wins
  typedef logic [EXC_W-1:0] excp_vec_t;

  localparam int EXC_INT  = 0;
  localparam int EXC_ADEF = 1;
  localparam int EXC_ADEM = 2;
  localparam int EXC_ALE  = 3;
  localparam int EXC_SYS  = 4;
  localparam int EXC_BRK  = 5;
  localparam int EXC_INE  = 6;
  localparam int EXC_IPE  = 7;

  typedef logic [5:0] ecode_t;

  localparam ecode_t ECODE_INT = 6'h0;
  localparam ecode_t ECODE_ADE = 6'h8;
  localparam ecode_t ECODE_ALE = 6'h9;
  localparam ecode_t ECODE_SYS = 6'hb;
  localparam ecode_t ECODE_BRK = 6'hc;
  localparam ecode_t ECODE_INE = 6'hd;
  localparam ecode_t ECODE_IPE = 6'he;

  typedef logic [8:0] esubcode_t;

  localparam esubcode_t ESUB_NONE = 9'd0;
  localparam esubcode_t ESUB_ADEM = 9'd1;

endpackage

`default_nettype wire

//--- rtl/csr_addr_pkg.sv
`default_nettype none

package csr_addr_pkg;

  typedef logic [13:0] csr_addr_t;
  typedef logic [31:0] csr_data_t;
  typedef logic [1:0]  rdcnt_t;
  typedef logic [63:0] stable_cnt_t;

  localparam rdcnt_t RDCNT_NONE  = 2'd0;
  localparam rdcnt_t RDCNT_ID    = 2'd1;
  localparam rdcnt_t RDCNT_VLOW  = 2'd2;
  localparam rdcnt_t RDCNT_VHIGH = 2'd3;

  localparam csr_addr_t CSR_CRMD   = 14'h0;
  localparam csr_addr_t CSR_PRMD   = 14'h1;
  localparam csr_addr_t CSR_ECTL   = 14'h4;
  localparam csr_addr_t CSR_ESTAT  = 14'h5;
  localparam csr_addr_t CSR_ERA    = 14'h6;
  localparam csr_addr_t CSR_BADV   = 14'h7;
  localparam csr_addr_t CSR_EENTRY = 14'hc;
  localparam csr_addr_t CSR_SAVE0  = 14'h30;
  localparam csr_addr_t CSR_SAVE1  = 14'h31;
  localparam csr_addr_t CSR_SAVE2  = 14'h32;
  localparam csr_addr_t CSR_SAVE3  = 14'h33;
  localparam csr_addr_t CSR_TID    = 14'h40;
  localparam csr_addr_t CSR_TCFG   = 14'h41;
  localparam csr_addr_t CSR_TVAL   = 14'h42;
  localparam csr_addr_t CSR_TICLR  = 14'h44;

  localparam int CRMD_PLV_MSB       = 1;
  localparam int CRMD_PLV_LSB       = 0;
  localparam int CRMD_IE            = 2;
  localparam int PRMD_PPLV_MSB      = 1;
  localparam int PRMD_PPLV_LSB      = 0;
  localparam int PRMD_PIE           = 2;
  localparam int ESTAT_IS_MSB       = 12;
  localparam int ESTAT_IS_LSB       = 0;
  localparam int ESTAT_ECODE_MSB    = 21;
  localparam int ESTAT_ECODE_LSB    = 16;
  localparam int ESTAT_ESUBCODE_MSB = 30;
  localparam int ESTAT_ESUBCODE_LSB = 22;
  localparam int ESTAT_TI_BIT       = 11;
  localparam int TCFG_EN            = 0;
  localparam int TCFG_PERIODIC      = 1;
  localparam int TCFG_INITVAL_MSB   = 31;
  localparam int TCFG_INITVAL_LSB   = 2;
  localparam int TICLR_CLR          = 0;
  localparam int EENTRY_VA_MSB      = 31;
  localparam int EENTRY_VA_LSB      = 6;
  localparam int ECTL_LIE_MSB       = 12;
  localparam int ECTL_LIE_LSB       = 0;

  // lie bit 10 has no source and stays zero
  localparam logic [12:0] ECTL_LIE_MASK = 13'h1bff;

endpackage

`default_nettype wire
